// File: dino_runner.f
+incdir+include
logic/dino_runner_pkg.sv
logic/frame_sequencer.sv
logic/pixel_raster.sv
logic/dino_jump.sv
logic/obstacle_motion.sv
logic/score_keeper.sv
logic/dino_runner_top.sv
tb/tb_clock.sv
tb/dino_runner_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line is printed

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module dino_runner_tb -f dino_runner.f; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vdino_runner_tb)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
	exit 0
fi

echo "pass line not found in simulation output"
exit 1

// File: tb/dino_runner_tb.sv
// one full game per table entry and each frame takes about 17k cycles, so the run is millions
`timescale 1ns/10ps

module dino_runner_tb;
	import dino_runner_pkg::*;
	// guard is already set by the rasterizer's copy
	`undef DINO_SPRITE_SVH
	`include "dino_sprite.svh"

	localparam int NUM_TESTS = 3;
	localparam int WAIT_LIMIT = 64;
	localparam int SCORE_FRAMES = 4;

	typedef struct packed {
		int frames;
		int jump_on;
		int jump_off;
		colour_t ground;
		logic exp_alive;
		logic [7:0] exp_score;
	} test_vec_t;

	// jump is high for the steps of frames jump_on up to jump_off - 1
	localparam test_vec_t TESTS [NUM_TESTS] = '{
		'{6, 1000, 1000, 3'b010, 1'b1, 8'd0},
		'{136, 0, 1, 3'b100, 1'b0, 8'd33},
		'{160, 0, 131, 3'b011, 1'b1, 8'd40}
	};
	string names [NUM_TESTS] = '{"no_jump", "early_jump_hit", "held_jump_wrap"};

	logic clk;
	logic rst;
	logic restart;
	logic start;
	logic jump;
	colour_t ground_colour;
	logic plot;
	pixel_t pixel;
	logic [7:0] score;
	logic alive;

	int cur;
	int test_errs;

	// reference model of the game state
	coord_y_t m_y;
	logic m_rising;
	coord_x_t m_x;
	coord_y_t m_oy;
	logic m_running;
	logic [3:0] m_lfsr;
	logic m_alive;
	logic [7:0] m_score;
	int m_cnt;

	tb_clock u_clock (
		.restart(restart),
		.clk(clk),
		.rst(rst)
	);

	dino_runner_top #(
		.HOLD_CYCLES(8),
		.SCORE_FRAMES(SCORE_FRAMES)
	) DUT (
		.clk(clk),
		.rst(rst),
		.start(start),
		.jump(jump),
		.ground_colour(ground_colour),
		.plot(plot),
		.pixel(pixel),
		.score(score),
		.alive(alive)
	);

	task automatic compare_value(input string what, input int expv, input int actv);
		if (expv != actv) begin
			if (test_errs < 10)
				$display("MISMATCH %s %s: expected %0h actual %0h", names[cur], what, expv, actv);
			test_errs++;
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("ERROR: timed out waiting for %s in test %s", what, names[cur]);
		$display("Some tests failed");
		$finish;
	endtask

	// next cycle with plot high, pixel sampled mid-cycle
	task automatic wait_write(output pixel_t px);
		int n;
		n = 0;
		@(negedge clk);
		while (!plot && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!plot)
			abort_on_timeout("a pixel write");
		px = pixel;
	endtask

	task automatic reset_model();
		m_y = DINO_Y_REST;
		m_rising = 1'b0;
		m_x = OBST_X_START;
		m_oy = OBST_Y_BASE;
		m_running = 1'b0;
		m_lfsr = 4'd0;
		m_alive = 1'b1;
		m_score = 8'd0;
		m_cnt = 0;
	endtask

	task automatic model_step(input logic j);
		// jump goes straight up to the top row, then back down
		if (m_rising) begin
			m_y = m_y - 7'd1;
			if (m_y == DINO_Y_TOP)
				m_rising = 1'b0;
		end else if (j && m_y == DINO_Y_REST) begin
			m_y = m_y - 7'd1;
			m_rising = 1'b1;
		end else if (m_y != DINO_Y_REST) begin
			m_y = m_y + 7'd1;
		end
		if (m_running) begin
			m_lfsr = {m_lfsr[2:0], ~(m_lfsr[3] ^ m_lfsr[2])};
			if (m_x == 8'd0) begin
				m_x = OBST_X_START;
				m_oy = OBST_Y_BASE - OBST_Y_STEP * 7'(m_lfsr[1:0]);
			end else begin
				m_x = m_x - 8'd1;
			end
		end
		if (j)
			m_running = 1'b1;
		// collision uses the positions after the step
		if (m_running && m_alive) begin
			if (m_x >= DINO_X - 8'd2 && m_x <= DINO_X + 8'd2 && m_y >= m_oy - 7'd2) begin
				m_alive = 1'b0;
			end else begin
				m_cnt++;
				if (m_cnt == SCORE_FRAMES) begin
					m_cnt = 0;
					m_score = m_score + 8'd1;
				end
			end
		end
	endtask

	task automatic run_game(input int t);
		pixel_t px;
		pixel_t exp_px;
		int n;
		logic j;
		@(negedge clk);
		restart = 1'b1;
		start = 1'b0;
		jump = 1'b0;
		ground_colour = TESTS[t].ground;
		@(negedge clk);
		restart = 1'b0;
		n = 0;
		while (rst && n < 40) begin
			@(negedge clk);
			n++;
		end
		if (rst)
			abort_on_timeout("reset release");
		reset_model();
		for (int i = 0; i < 50; i++) begin
			@(negedge clk);
			compare_value("idle plot", 0, int'(plot));
			compare_value("idle score", 0, int'(score));
			compare_value("idle alive", 1, int'(alive));
		end
		start = 1'b1;
		for (int i = 0; i < 160; i++) begin
			wait_write(px);
			exp_px = {8'(i), GROUND_Y, TESTS[t].ground};
			compare_value("ground pixel", int'(exp_px), int'(px));
		end
		start = 1'b0;
		for (int f = 0; f < TESTS[t].frames; f++) begin
			for (int i = 0; i < 31; i++) begin
				wait_write(px);
				exp_px.x = 8'(int'(DINO_X) + int'(DINO_SPRITE[i].dx));
				exp_px.y = 7'(int'(m_y) + int'(DINO_SPRITE[i].dy));
				exp_px.colour = COLOUR_WHITE;
				compare_value("dino pixel", int'(exp_px), int'(px));
			end
			for (int i = 0; i < 64; i++) begin
				wait_write(px);
				exp_px = {m_x + 8'(i % 8), m_oy + 7'(i / 8), COLOUR_MAGENTA};
				compare_value("obstacle pixel", int'(exp_px), int'(px));
			end
			compare_value("frame score", int'(m_score), int'(score));
			compare_value("frame alive", int'(m_alive), int'(alive));
			// sampled by the step at the end of this frame
			j = (f >= TESTS[t].jump_on && f < TESTS[t].jump_off);
			jump = j;
			for (int i = 0; i < 16960; i++) begin
				wait_write(px);
				exp_px = {8'(i % 160), 7'(i / 160), COLOUR_BLACK};
				compare_value("clear pixel", int'(exp_px), int'(px));
			end
			model_step(j);
		end
		// score and alive have settled by the first write of the next frame
		wait_write(px);
		compare_value("model score", int'(m_score), int'(score));
		compare_value("model alive", int'(m_alive), int'(alive));
		compare_value("final score", int'(TESTS[t].exp_score), int'(score));
		compare_value("final alive", int'(TESTS[t].exp_alive), int'(alive));
	endtask

	initial begin
		int passed;
		int failed;
		restart = 1'b0;
		start = 1'b0;
		jump = 1'b0;
		ground_colour = '0;
		passed = 0;
		failed = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			cur = t;
			test_errs = 0;
			run_game(t);
			if (test_errs == 0) begin
				passed++;
				$display("test %s: ok", names[t]);
			end else begin
				failed++;
				$display("test %s: %0d errors", names[t], test_errs);
			end
		end
		$display("tests run %0d, ok %0d, failed %0d", NUM_TESTS, passed, failed);
		if (failed == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: tb/tb_clock.sv
// 10 ns clock with a 16-cycle reset at power-up and again after each restart pulse
`timescale 1ns/10ps

module tb_clock (
	input  logic restart,
	output logic clk,
	output logic rst
);
	int rst_cnt = 16;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		if (restart)
			rst_cnt <= 16;
		else if (rst_cnt != 0)
			rst_cnt <= rst_cnt - 1;
	end

	assign rst = (rst_cnt != 0);

endmodule

// File: logic/dino_runner_top.sv
// runner game drawn as a pixel-write stream and ends before any VGA adapter
`timescale 1ns/10ps

module dino_runner_top #(
	parameter int HOLD_CYCLES = 250000,
	parameter int SCORE_FRAMES = 200
) (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic jump,
	input  dino_runner_pkg::colour_t ground_colour,
	output logic plot,
	output dino_runner_pkg::pixel_t pixel,
	output logic [7:0] score,
	output logic alive
);
	import dino_runner_pkg::*;

	frame_phase_e phase;
	logic phase_done;
	logic step;
	logic running;
	coord_y_t dino_y;
	obstacle_t obstacle;

	frame_sequencer #(
		.HOLD_CYCLES(HOLD_CYCLES)
	) u_frame_sequencer (
		.clk(clk),
		.rst(rst),
		.start(start),
		.phase_done(phase_done),
		.phase(phase),
		.step(step)
	);

	pixel_raster u_pixel_raster (
		.clk(clk),
		.rst(rst),
		.phase(phase),
		.dino_y(dino_y),
		.obstacle(obstacle),
		.ground_colour(ground_colour),
		.plot(plot),
		.pixel(pixel),
		.phase_done(phase_done)
	);

	dino_jump u_dino_jump (
		.clk(clk),
		.rst(rst),
		.step(step),
		.jump(jump),
		.dino_y(dino_y)
	);

	obstacle_motion u_obstacle_motion (
		.clk(clk),
		.rst(rst),
		.step(step),
		.jump(jump),
		.obstacle(obstacle),
		.running(running)
	);

	score_keeper #(
		.SCORE_FRAMES(SCORE_FRAMES)
	) u_score_keeper (
		.clk(clk),
		.rst(rst),
		.step(step),
		.running(running),
		.dino_y(dino_y),
		.obstacle(obstacle),
		.score(score),
		.alive(alive)
	);

endmodule

// File: logic/score_keeper.sv
// collision and score checked on the cycle after step and SCORE_FRAMES must be at least 1
`timescale 1ns/10ps

module score_keeper #(
	parameter int SCORE_FRAMES = 200
) (
	input  logic clk,
	input  logic rst,
	input  logic step,
	input  logic running,
	input  dino_runner_pkg::coord_y_t dino_y,
	input  dino_runner_pkg::obstacle_t obstacle,
	output logic [7:0] score,
	output logic alive
);
	import dino_runner_pkg::*;

	localparam int CNT_W = $clog2(SCORE_FRAMES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCORE_FRAMES - 1);

	logic check;
	logic hit;
	logic [CNT_W-1:0] frame_cnt;

	// obstacle within two columns of the dino and the dino low enough to touch it
	assign hit = (obstacle.x >= DINO_X - 8'd2) && (obstacle.x <= DINO_X + 8'd2)
		&& (dino_y >= obstacle.y - 7'd2);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			check <= 1'b0;
			alive <= 1'b1;
			score <= '0;
			frame_cnt <= '0;
		end else begin
			// positions settle one cycle after step
			check <= step;
			if (check && running && alive) begin
				if (hit) begin
					alive <= 1'b0;
				end else if (frame_cnt == CNT_LAST) begin
					frame_cnt <= '0;
					score <= score + 8'd1;
				end else begin
					frame_cnt <= frame_cnt + CNT_W'(1);
				end
			end
		end
	end

endmodule

// File: logic/obstacle_motion.sv
// obstacle position and LFSR height which stay frozen until the first step with jump high
`timescale 1ns/10ps

module obstacle_motion (
	input  logic clk,
	input  logic rst,
	input  logic step,
	input  logic jump,
	output dino_runner_pkg::obstacle_t obstacle,
	output logic running
);
	import dino_runner_pkg::*;

	logic [3:0] lfsr;
	logic [3:0] lfsr_next;

	// xnor feedback so the all-zero reset state is legal
	assign lfsr_next = {lfsr[2:0], ~(lfsr[3] ^ lfsr[2])};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			obstacle.x <= OBST_X_START;
			obstacle.y <= OBST_Y_BASE;
			running <= 1'b0;
			lfsr <= 4'd0;
		end else if (step) begin
			if (jump)
				running <= 1'b1;
			if (running) begin
				lfsr <= lfsr_next;
				if (obstacle.x == '0) begin
					// back to the right edge at a new height
					obstacle.x <= OBST_X_START;
					obstacle.y <= OBST_Y_BASE - OBST_Y_STEP * {5'd0, lfsr_next[1:0]};
				end else begin
					obstacle.x <= obstacle.x - 8'd1;
				end
			end
		end
	end

endmodule

// File: logic/dino_jump.sv
// dino anchor row which moves by one row per step cycle only
`timescale 1ns/10ps

module dino_jump (
	input  logic clk,
	input  logic rst,
	input  logic step,
	input  logic jump,
	output dino_runner_pkg::coord_y_t dino_y
);
	import dino_runner_pkg::*;

	logic rising;
	logic going_up;

	// a jump only starts from the ground
	assign going_up = rising || (jump && (dino_y == DINO_Y_REST));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			dino_y <= DINO_Y_REST;
			rising <= 1'b0;
		end else if (step) begin
			if (going_up) begin
				dino_y <= dino_y - 7'd1;
				// turn around once the top row is reached
				rising <= (dino_y - 7'd1) != DINO_Y_TOP;
			end else if (dino_y != DINO_Y_REST) begin
				dino_y <= dino_y + 7'd1;
			end
		end
	end

endmodule

// File: logic/pixel_raster.sv
// pixel write generator with one registered stage and no back-pressure on plot
`timescale 1ns/10ps

module pixel_raster (
	input  logic clk,
	input  logic rst,
	input  dino_runner_pkg::frame_phase_e phase,
	input  dino_runner_pkg::coord_y_t dino_y,
	input  dino_runner_pkg::obstacle_t obstacle,
	input  dino_runner_pkg::colour_t ground_colour,
	output logic plot,
	output dino_runner_pkg::pixel_t pixel,
	output logic phase_done
);
	import dino_runner_pkg::*;
	`include "dino_sprite.svh"

	// dino pixels first, then the obstacle block
	localparam logic [6:0] SPR_LAST = 7'(DINO_PIXELS) + 7'(OBST_SIZE) * 7'(OBST_SIZE) - 7'd1;
	localparam coord_x_t LAST_X = SCREEN_W - 8'd1;
	localparam coord_y_t CLR_LAST_Y = GROUND_Y - 7'd1;

	coord_x_t gnd_x;
	logic [6:0] spr_idx;
	coord_x_t clr_x;
	coord_y_t clr_y;

	logic [5:0] obst_idx;
	sprite_off_t off;
	logic gnd_last;
	logic spr_last;
	logic clr_last;
	logic draw;
	pixel_t next_pixel;

	always_comb begin
		obst_idx = 6'(spr_idx - 7'(DINO_PIXELS));
		off = (spr_idx < 7'(DINO_PIXELS)) ? DINO_SPRITE[spr_idx[4:0]] : '0;
		gnd_last = (gnd_x == LAST_X);
		spr_last = (spr_idx == SPR_LAST);
		clr_last = (clr_x == LAST_X) && (clr_y == CLR_LAST_Y);
		draw = 1'b0;
		phase_done = 1'b0;
		next_pixel = '0;
		case (phase)
			PH_GROUND: begin
				draw = 1'b1;
				phase_done = gnd_last;
				next_pixel.x = gnd_x;
				next_pixel.y = GROUND_Y;
				next_pixel.colour = ground_colour;
			end
			PH_SPRITES: begin
				draw = 1'b1;
				phase_done = spr_last;
				if (spr_idx < 7'(DINO_PIXELS)) begin
					// sign-extend the table offsets
					next_pixel.x = DINO_X + {{4{off.dx[3]}}, off.dx};
					next_pixel.y = dino_y + {{3{off.dy[3]}}, off.dy};
					next_pixel.colour = COLOUR_WHITE;
				end else begin
					// raster order, row in bits 5..3
					next_pixel.x = obstacle.x + {5'd0, obst_idx[2:0]};
					next_pixel.y = obstacle.y + {4'd0, obst_idx[5:3]};
					next_pixel.colour = COLOUR_MAGENTA;
				end
			end
			PH_CLEAR: begin
				draw = 1'b1;
				phase_done = clr_last;
				next_pixel.x = clr_x;
				next_pixel.y = clr_y;
				next_pixel.colour = COLOUR_BLACK;
			end
			default: begin
				draw = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			plot <= 1'b0;
			pixel <= '0;
			gnd_x <= '0;
			spr_idx <= '0;
			clr_x <= '0;
			clr_y <= '0;
		end else begin
			plot <= draw;
			if (draw)
				pixel <= next_pixel;
			case (phase)
				PH_GROUND: begin
					gnd_x <= gnd_last ? '0 : gnd_x + 8'd1;
				end
				PH_SPRITES: begin
					spr_idx <= spr_last ? '0 : spr_idx + 7'd1;
				end
				PH_CLEAR: begin
					if (clr_x == LAST_X) begin
						clr_x <= '0;
						clr_y <= clr_last ? '0 : clr_y + 7'd1;
					end else begin
						clr_x <= clr_x + 8'd1;
					end
				end
				default: begin
					gnd_x <= gnd_x;
				end
			endcase
		end
	end

endmodule

// File: logic/frame_sequencer.sv
// frame phase FSM and HOLD_CYCLES must be at least 1
`timescale 1ns/10ps

module frame_sequencer #(
	parameter int HOLD_CYCLES = 250000
) (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic phase_done,
	output dino_runner_pkg::frame_phase_e phase,
	output logic step
);
	import dino_runner_pkg::*;

	localparam int HOLD_W = $clog2(HOLD_CYCLES + 1);
	localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(HOLD_CYCLES - 1);

	frame_phase_e next_phase;
	logic [HOLD_W-1:0] hold_cnt;
	logic hold_end;

	assign hold_end = (phase == PH_HOLD) && (hold_cnt == HOLD_LAST);

	// game state modules advance only here
	assign step = (phase == PH_STEP);

	always_comb begin
		next_phase = phase;
		case (phase)
			PH_IDLE: begin
				if (start)
					next_phase = PH_GROUND;
			end
			// ground is drawn once per game
			PH_GROUND: begin
				if (phase_done)
					next_phase = PH_SPRITES;
			end
			PH_SPRITES: begin
				if (phase_done)
					next_phase = PH_HOLD;
			end
			PH_HOLD: begin
				if (hold_end)
					next_phase = PH_CLEAR;
			end
			PH_CLEAR: begin
				if (phase_done)
					next_phase = PH_STEP;
			end
			PH_STEP: begin
				next_phase = PH_SPRITES;
			end
			default: begin
				next_phase = PH_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= PH_IDLE;
			hold_cnt <= '0;
		end else begin
			phase <= next_phase;
			if (hold_end)
				hold_cnt <= '0;
			else if (phase == PH_HOLD)
				hold_cnt <= hold_cnt + HOLD_W'(1);
		end
	end

endmodule

// File: logic/dino_runner_pkg.sv
// screen geometry and game constants for a 160x120 framebuffer with 3-bit colour
package dino_runner_pkg;

	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;
	typedef logic [2:0] colour_t;

	// one framebuffer write
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		colour_t  colour;
	} pixel_t;

	// top-left corner of the obstacle block
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
	} obstacle_t;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_GROUND,
		PH_SPRITES,
		PH_HOLD,
		PH_CLEAR,
		PH_STEP
	} frame_phase_e;

	localparam coord_x_t SCREEN_W = 8'd160;
	// play area is every row above the ground line
	localparam coord_y_t GROUND_Y = 7'd106;

	localparam coord_x_t DINO_X      = 8'd15;
	localparam coord_y_t DINO_Y_REST = 7'd100;
	localparam coord_y_t DINO_Y_TOP  = 7'd60;

	localparam coord_x_t OBST_X_START = 8'd151;
	localparam coord_y_t OBST_Y_BASE  = 7'd98;
	localparam coord_y_t OBST_Y_STEP  = 7'd15;
	localparam logic [3:0] OBST_SIZE  = 4'd8;

	localparam logic [4:0] DINO_PIXELS = 5'd31;

	localparam colour_t COLOUR_WHITE   = 3'b111;
	localparam colour_t COLOUR_MAGENTA = 3'b101;
	localparam colour_t COLOUR_BLACK   = 3'b000;

endpackage

// File: include/dino_sprite.svh
// dino sprite offsets from the anchor and dino_runner_pkg must be imported before inclusion
`ifndef DINO_SPRITE_SVH
`define DINO_SPRITE_SVH

typedef struct packed {
	logic signed [3:0] dx;
	logic signed [3:0] dy;
} sprite_off_t;

// body cross and legs, then the 4x4 head block above it
localparam sprite_off_t DINO_SPRITE [DINO_PIXELS] = '{
	'{ 4'sd0,  4'sd0},
	'{-4'sd1,  4'sd0},
	'{-4'sd2,  4'sd0},
	'{ 4'sd1,  4'sd0},
	'{ 4'sd2,  4'sd0},
	'{ 4'sd0,  4'sd1},
	'{ 4'sd0,  4'sd2},
	'{ 4'sd0, -4'sd1},
	'{ 4'sd0, -4'sd2},
	'{-4'sd1,  4'sd3},
	'{ 4'sd1,  4'sd3},
	'{ 4'sd2,  4'sd4},
	'{-4'sd2,  4'sd4},
	'{ 4'sd3,  4'sd5},
	'{-4'sd3,  4'sd5},
	'{-4'sd2, -4'sd6},
	'{-4'sd2, -4'sd5},
	'{-4'sd2, -4'sd4},
	'{-4'sd2, -4'sd3},
	'{-4'sd1, -4'sd6},
	'{-4'sd1, -4'sd5},
	'{-4'sd1, -4'sd4},
	'{-4'sd1, -4'sd3},
	'{ 4'sd0, -4'sd6},
	'{ 4'sd0, -4'sd5},
	'{ 4'sd0, -4'sd4},
	'{ 4'sd0, -4'sd3},
	'{ 4'sd1, -4'sd6},
	'{ 4'sd1, -4'sd5},
	'{ 4'sd1, -4'sd4},
	'{ 4'sd1, -4'sd3}
};

`endif
